// ==== list.f ====
+incdir+rtl
rtl/ucode_pkg.sv
rtl/op_category.sv
rtl/ucode_seq.sv
rtl/ucode_rom.sv
rtl/ucode_ctrl.sv
testbench/ucode_assert.sv
testbench/tb_ucode.sv

// ==== rtl/op_category.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode and postbyte classification, purely combinational
// only the reduced opcode subset is known, anything else
// and any unsupported postbyte maps to BUSERROR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "ucode_defs.svh"

module op_category(
    input  logic [`UC_OP_W-1:0] op,       // current opcode
    input  logic [`UC_OP_W-1:0] mdata,    // postbyte for indexed ops
    input  ucode_pkg::opcat_e   post_idx, // category latched at entry
    output ucode_pkg::opcat_e   opcat,
    output ucode_pkg::opcat_e   nx_cat,
    output ucode_pkg::opcat_e   idx_cat
);

    import ucode_pkg::*;

    // indexed mode from postbyte bit 7 and bits 2:0
    always_comb begin
        case ({mdata[7], mdata[2:0]})
            4'b0_110: idx_cat = IDX_R;
            4'b0_100: idx_cat = IDX_OFS8;
            default:  idx_cat = BUSERROR;
        endcase
    end

    // nx_cat only matters for indexed ops, where the routine
    // after the postbyte detour depends on the opcode
    always_comb begin
        nx_cat = post_idx;
        case (op)
            LDA_IMM,
            ADDA_IMM: opcat = SINGLE_ALU;
            INCA:     opcat = A_INH;
            INCB:     opcat = B_INH;
            LDA_IDX: begin
                opcat  = PARSE_IDX;
                nx_cat = ALU_IDX;
            end
            STA: begin
                opcat  = PARSE_IDX;
                nx_cat = STORE8;
            end
            BRA:      opcat = SBRANCH;
            RTI:      opcat = RTIT;
            NOP:      opcat = NOPE;
            default:  opcat = BUSERROR;   // unknown opcode
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ucode_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcode control unit top
// op and mdata must be stable while the routine end is
// latched; strobes trail their address by one cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "ucode_defs.svh"

module ucode_ctrl(
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [`UC_OP_W-1:0] op,
    input  logic [`UC_OP_W-1:0] mdata,
    input  logic                mem_busy,
    input  logic                nmi_n,
    input  logic                firq_n,
    input  logic                irq_n,
    output logic                ni,
    output logic                idx_jmp,
    output logic                idx_ret,
    output logic                skip_noind,
    output logic                int_en,
    output logic                up_lda,
    output logic                up_ldb,
    output logic                we,
    output logic                set_pc_branch8,
    output logic                rti_cc,
    output logic [2:0]          idx_rsel,
    output logic [1:0]          idx_asel,
    output logic                idx_post,
    output logic [3:0]          intvec,
    output logic                buserror
);

    import ucode_pkg::*;

    opcat_e                opcat;
    opcat_e                nx_cat;
    opcat_e                idx_cat;
    opcat_e                post_idx;
    logic [`UC_ADR_W-1:0]  addr;

    op_category u_cat(
        .op       (op),
        .mdata    (mdata),
        .post_idx (post_idx),
        .opcat    (opcat),
        .nx_cat   (nx_cat),
        .idx_cat  (idx_cat)
    );

    ucode_seq u_seq(
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .mem_busy   (mem_busy),
        .nmi_n      (nmi_n),
        .firq_n     (firq_n),
        .irq_n      (irq_n),
        .op4        (op[4]),
        .ni         (ni),
        .idx_jmp    (idx_jmp),
        .idx_ret    (idx_ret),
        .skip_noind (skip_noind),
        .int_en     (int_en),
        .opcat      (opcat),
        .nx_cat     (nx_cat),
        .idx_cat    (idx_cat),
        .mdata      (mdata),
        .addr       (addr),
        .post_idx   (post_idx),
        .idx_rsel   (idx_rsel),
        .idx_asel   (idx_asel),
        .idx_post   (idx_post),
        .intvec     (intvec),
        .buserror   (buserror)
    );

    ucode_rom u_rom(
        .clk            (clk),
        .rst            (rst),
        .cen            (cen),
        .mem_busy       (mem_busy),
        .addr           (addr),
        .ni             (ni),
        .idx_jmp        (idx_jmp),
        .idx_ret        (idx_ret),
        .skip_noind     (skip_noind),
        .int_en         (int_en),
        .up_lda         (up_lda),
        .up_ldb         (up_ldb),
        .we             (we),
        .set_pc_branch8 (set_pc_branch8),
        .rti_cc         (rti_cc)
    );

endmodule

`default_nettype wire

// ==== rtl/ucode_defs.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths shared by the microcode control unit
// the microcode address is the category followed by the row,
// so every routine owns 2**UC_ROW_W rows
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UCODE_DEFS_SVH
`define UCODE_DEFS_SVH

// opcode and indexed postbyte
`define UC_OP_W  8

// routine category, one of 16
`define UC_CAT_W 4

// rows per routine as a power of two
`define UC_ROW_W 3

// microcode address
`define UC_ADR_W (`UC_CAT_W + `UC_ROW_W)

// control word, one bit per strobe
`define UC_CW_W  10

`endif

// ==== rtl/ucode_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// routine categories and the supported opcode subset
// category values are the upper bits of the ucode address,
// so reordering them moves routines in the ROM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "ucode_defs.svh"

package ucode_pkg;

    typedef enum logic [`UC_CAT_W-1:0] {
        RESET      = 4'd0,
        SINGLE_ALU,          // 8-bit immediate ALU op
        A_INH,
        B_INH,
        PARSE_IDX,           // postbyte decode entry
        ALU_IDX,
        STORE8,
        SBRANCH,
        RTIT,
        NOPE,
        IDX_R,               // ,R
        IDX_OFS8,            // 8-bit offset,R
        NMI,
        FIRQ,
        IRQ,
        BUSERROR   = 4'd15   // stop condition
    } opcat_e;

    typedef enum logic [`UC_OP_W-1:0] {
        LDA_IMM  = 8'h86,
        ADDA_IMM = 8'h8B,
        INCA     = 8'h4C,
        INCB     = 8'h5C,
        LDA_IDX  = 8'hA6,
        STA      = 8'hA7,
        BRA      = 8'h20,
        RTI      = 8'h3B,
        NOP      = 8'h12
    } opcode_e;

endpackage

`default_nettype wire

// ==== rtl/ucode_rom.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control store as a case table with a registered output
// rows not listed read as zero; a routine's rows after ni
// must stay empty since two of them are fetched anyway
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "ucode_defs.svh"

module ucode_rom(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic                 mem_busy,
    input  logic [`UC_ADR_W-1:0] addr,
    output logic                 ni,
    output logic                 idx_jmp,
    output logic                 idx_ret,
    output logic                 skip_noind,
    output logic                 int_en,
    output logic                 up_lda,
    output logic                 up_ldb,
    output logic                 we,
    output logic                 set_pc_branch8,
    output logic                 rti_cc
);

    import ucode_pkg::*;

    // control word bit positions
    localparam int B_NI      = 0;
    localparam int B_IDX_JMP = 1;
    localparam int B_IDX_RET = 2;
    localparam int B_SKIP    = 3;
    localparam int B_INT_EN  = 4;
    localparam int B_LDA     = 5;
    localparam int B_LDB     = 6;
    localparam int B_WE      = 7;
    localparam int B_BR8     = 8;
    localparam int B_RTI     = 9;

    localparam logic [`UC_ROW_W-1:0] R0 = 0;
    localparam logic [`UC_ROW_W-1:0] R1 = 1;

    opcat_e               cat;
    logic [`UC_ROW_W-1:0] row;
    logic [`UC_CW_W-1:0]  word;    // table output
    logic [`UC_CW_W-1:0]  ucode;   // registered word

    assign cat = opcat_e'(addr[`UC_ADR_W-1:`UC_ROW_W]);
    assign row = addr[`UC_ROW_W-1:0];

    always_comb begin
        word = '0;
        case (cat)
            RESET:      word[B_NI] = row == R0;
            SINGLE_ALU: begin
                word[B_LDA] = row == R0;
                word[B_NI]  = row == R1;
            end
            A_INH:      word[B_LDA] = row == R0;
            B_INH:      word[B_LDB] = row == R0;
            PARSE_IDX:  word[B_IDX_JMP] = row == R0;
            IDX_R:      word[B_IDX_RET] = row == R0;
            IDX_OFS8:   word[B_IDX_RET] = row == R1;   // offset fetch slot first
            ALU_IDX:    word[B_LDA] = row == R0;
            STORE8:     word[B_WE]  = row == R0;
            SBRANCH:    word[B_BR8] = row == R0;
            RTIT:       word[B_RTI] = row == R0;
            NMI, FIRQ, IRQ: begin
                word[B_INT_EN] = row == R0 || row == R1;
                word[B_NI]     = row == R1;
            end
            default: ;
        endcase
        // one-row routines end on their only row
        if (row == R0 && (cat == A_INH || cat == B_INH || cat == ALU_IDX ||
            cat == STORE8 || cat == SBRANCH || cat == RTIT || cat == NOPE)) begin
            word[B_NI] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ucode <= '0;
        end else if (cen && !mem_busy) begin
            ucode <= word;   // held while memory is busy
        end
    end

    assign ni             = ucode[B_NI];
    assign idx_jmp        = ucode[B_IDX_JMP];
    assign idx_ret        = ucode[B_IDX_RET];
    assign skip_noind     = ucode[B_SKIP];
    assign int_en         = ucode[B_INT_EN];
    assign up_lda         = ucode[B_LDA];
    assign up_ldb         = ucode[B_LDB];
    assign we             = ucode[B_WE];
    assign set_pc_branch8 = ucode[B_BR8];
    assign rti_cc         = ucode[B_RTI];

endmodule

`default_nettype wire

// ==== rtl/ucode_seq.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcode sequencer, one address step per enabled cycle
// mem_busy freezes all state; BUSERROR holds until reset
// a new routine starts one cycle after ni is latched
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "ucode_defs.svh"

module ucode_seq(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic                 mem_busy,
    input  logic                 nmi_n,
    input  logic                 firq_n,
    input  logic                 irq_n,
    input  logic                 op4,        // opcode bit 4, for skip_noind
    input  logic                 ni,
    input  logic                 idx_jmp,
    input  logic                 idx_ret,
    input  logic                 skip_noind,
    input  logic                 int_en,
    input  ucode_pkg::opcat_e    opcat,
    input  ucode_pkg::opcat_e    nx_cat,
    input  ucode_pkg::opcat_e    idx_cat,
    input  logic [`UC_OP_W-1:0]  mdata,
    output logic [`UC_ADR_W-1:0] addr,
    output ucode_pkg::opcat_e    post_idx,
    output logic [2:0]           idx_rsel,
    output logic [1:0]           idx_asel,
    output logic                 idx_post,
    output logic [3:0]           intvec,
    output logic                 buserror
);

    import ucode_pkg::*;

    localparam logic [`UC_ROW_W-1:0] ROW0  = '0;
    localparam logic [`UC_ADR_W-1:0] STEP1 = 1;
    localparam logic [`UC_ADR_W-1:0] STEP2 = 2;

    logic                 nil;       // ni seen on the previous step
    logic [3:0]           cur_int;   // one-hot source of the current routine
    logic [`UC_CAT_W-1:0] addr_cat;

    assign addr_cat = addr[`UC_ADR_W-1:`UC_ROW_W];
    assign buserror = addr_cat == BUSERROR;
    assign intvec   = cur_int & {4{int_en}};

    always_ff @(posedge clk) begin
        if (rst) begin
            addr     <= {RESET, ROW0};
            cur_int  <= 4'b1000;
            nil      <= 1'b0;
            post_idx <= RESET;
            idx_rsel <= '0;
            idx_asel <= '0;
            idx_post <= 1'b0;
        end else if (cen && !buserror) begin
            idx_post <= 1'b0;   // single cycle pulse
            if (!mem_busy) begin
                nil  <= ni;
                addr <= addr + ((skip_noind && !op4) ? STEP2 : STEP1);
                if (nil) begin
                    post_idx <= nx_cat;   // routine after any indexed detour
                    if (!nmi_n) begin
                        cur_int <= 4'b0100;
                        addr    <= {NMI, ROW0};
                    end else if (!firq_n) begin
                        cur_int <= 4'b0010;
                        addr    <= {FIRQ, ROW0};
                    end else if (!irq_n) begin
                        cur_int <= 4'b0001;
                        addr    <= {IRQ, ROW0};
                    end else begin
                        cur_int <= 4'b0000;
                        addr    <= {opcat, ROW0};   // next opcode
                    end
                end
                // postbyte decode jumps to the addressing mode routine
                if (idx_jmp) begin
                    addr     <= {idx_cat, ROW0};
                    idx_rsel <= mdata[6:4];
                    idx_asel <= mdata[1:0];
                end
                if (idx_ret) begin
                    addr     <= {post_idx, ROW0};
                    idx_post <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ucode -f list.f -o sim_ucode \
    && ./obj_dir/sim_ucode +verilator+error+limit+100 \
    || { echo "simulation failed"; exit 1; }

echo "simulation done"
exit 0

// ==== testbench/tb_ucode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the microcode control unit; the bound
// checker does the comparing, this file only steers the DUT
// op and mdata change only when a routine end shows up
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "ucode_defs.svh"

module tb_ucode;

    import ucode_pkg::*;

    localparam int N_PLAIN    = 50;
    localparam int N_BUSY     = 50;
    localparam int CYC_ROUT   = 18;   // detour plus interrupt, stretched by busy
    localparam int MAX_CYCLES = (N_PLAIN + N_BUSY) * CYC_ROUT + 200;

    logic                clk;
    logic                rst;
    logic                cen;
    logic                mem_busy;
    logic                nmi_n;
    logic                firq_n;
    logic                irq_n;
    logic [`UC_OP_W-1:0] op;
    logic [`UC_OP_W-1:0] mdata;
    logic                ni;
    logic                idx_jmp;
    logic                idx_ret;
    logic                skip_noind;
    logic                int_en;
    logic                up_lda;
    logic                up_ldb;
    logic                we;
    logic                set_pc_branch8;
    logic                rti_cc;
    logic [2:0]          idx_rsel;
    logic [1:0]          idx_asel;
    logic                idx_post;
    logic [3:0]          intvec;
    logic                buserror;

    int   seed = 32'h14af;
    int   cycles = 0;
    logic busy_on;

    ucode_ctrl dut(.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one cycle, inputs land 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
        mem_busy = busy_on && (($random(seed) & 3) == 0);
    endtask

    task automatic wait_ni_rise();
        logic prev;
        prev = ni;
        step();
        while (!(ni && !prev)) begin
            prev = ni;
            step();
        end
    endtask

    task automatic apply_reset();
        busy_on = 1'b0;
        rst     = 1'b1;
        repeat (4) step();
        rst = 1'b0;
    endtask

    function automatic logic [`UC_OP_W-1:0] pick_op(input logic [31:0] r);
        case (r % 32'd9)
            0:       return LDA_IMM;
            1:       return ADDA_IMM;
            2:       return INCA;
            3:       return INCB;
            4:       return LDA_IDX;
            5:       return STA;
            6:       return BRA;
            7:       return RTI;
            default: return NOP;
        endcase
    endfunction

    // ,R or 8-bit offset with random register and address fields
    function automatic logic [`UC_OP_W-1:0] pick_postbyte(input logic [31:0] r);
        return {1'b0, r[6:3], r[0] ? 3'b110 : 3'b100};
    endfunction

    task automatic run_routines(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            wait_ni_rise();
            r     = $random(seed);
            op    = pick_op(r);
            mdata = pick_postbyte($random(seed));
            case (r[10:8])
                3'd0: nmi_n = 1'b0;
                3'd1: firq_n = 1'b0;
                3'd2: irq_n = 1'b0;
                3'd3: begin
                    nmi_n  = 1'b0;
                    firq_n = 1'b0;
                    irq_n  = 1'b0;
                end
                3'd4: begin
                    firq_n = 1'b0;
                    irq_n  = 1'b0;
                end
                default: ;
            endcase
            if (!(nmi_n && firq_n && irq_n)) begin
                step();
                step();   // held across the routine entry
                nmi_n  = 1'b1;
                firq_n = 1'b1;
                irq_n  = 1'b1;
            end
        end
    endtask

    task automatic force_buserror(input logic [`UC_OP_W-1:0] bad_op,
                                  input logic [`UC_OP_W-1:0] bad_post);
        wait_ni_rise();
        op    = bad_op;
        mdata = bad_post;
        while (!buserror) step();
        repeat (20) step();
        apply_reset();
    endtask

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (dut.u_assert.fail_count != 0) begin
            $display("Verification failed");
            $fatal(1, "assertion failure at %0t", $time);
        end else if (cycles >= MAX_CYCLES) begin
            $display("Verification failed");
            $fatal(1, "timeout, no end of test after %0d cycles", cycles);
        end
    end

    initial begin
        rst      = 1'b1;
        cen      = 1'b1;
        mem_busy = 1'b0;
        nmi_n    = 1'b1;
        firq_n   = 1'b1;
        irq_n    = 1'b1;
        op       = NOP;
        mdata    = '0;
        busy_on  = 1'b0;
        apply_reset();
        run_routines(N_PLAIN);
        busy_on = 1'b1;
        run_routines(N_BUSY);
        busy_on = 1'b0;
        force_buserror(8'hFF, 8'h00);   // unknown opcode
        force_buserror(STA, 8'h87);     // postbyte with bit 7 set
        run_routines(2);
        repeat (4) step();
        if (dut.u_assert.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "%0d assertion failures", dut.u_assert.fail_count);
        end
    end

endmodule

bind ucode_ctrl ucode_assert u_assert(.*);

`default_nettype wire

// ==== testbench/ucode_assert.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks for the microcode control unit, bound to
// the top level; assumes cen stays high and op holds from one
// routine end to the next; fail_count counts failed checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "ucode_defs.svh"

module ucode_assert(
    input logic                clk,
    input logic                rst,
    input logic                mem_busy,
    input logic                nmi_n,
    input logic                firq_n,
    input logic                irq_n,
    input logic [`UC_OP_W-1:0] op,
    input logic [`UC_OP_W-1:0] mdata,
    input logic                ni,
    input logic                idx_jmp,
    input logic                idx_ret,
    input logic                skip_noind,
    input logic                int_en,
    input logic                up_lda,
    input logic                up_ldb,
    input logic                we,
    input logic                set_pc_branch8,
    input logic                rti_cc,
    input logic [2:0]          idx_rsel,
    input logic [1:0]          idx_asel,
    input logic                idx_post,
    input logic [3:0]          intvec,
    input logic                buserror
);

    import ucode_pkg::*;

    localparam int W_NI  = 0;
    localparam int W_JMP = 1;
    localparam int W_LDA = 5;
    localparam int W_LDB = 6;
    localparam int W_BR8 = 8;
    localparam int W_RTI = 9;
    localparam int W_ERR = 10;

    int         fail_count = 0;
    logic [9:0] cw;

    assign cw = {rti_cc, set_pc_branch8, we, up_ldb, up_lda,
                 int_en, skip_noind, idx_ret, idx_jmp, ni};

    // first word of a routine, buserror in the top bit
    function automatic logic [10:0] first_word(input logic [`UC_OP_W-1:0] code);
        logic [10:0] w;
        w = '0;
        case (code)
            LDA_IMM,
            ADDA_IMM: w[W_LDA] = 1'b1;          // ni comes one row later
            INCA:     w[W_LDA] = 1'b1;
            INCB:     w[W_LDB] = 1'b1;
            LDA_IDX,
            STA:      w[W_JMP] = 1'b1;
            BRA:      w[W_BR8] = 1'b1;
            RTI:      w[W_RTI] = 1'b1;
            NOP:      ;
            default:  w[W_ERR] = 1'b1;          // empty word, stopped
        endcase
        if (code == INCA || code == INCB || code == BRA || code == RTI || code == NOP) begin
            w[W_NI] = 1'b1;
        end
        return w;
    endfunction

    // only ,R and 8-bit offset postbytes are supported
    function automatic logic postbyte_ok(input logic [`UC_OP_W-1:0] pb);
        return !pb[7] && (pb[2:0] == 3'b110 || pb[2:0] == 3'b100);
    endfunction

    a_reset_ni: assert property (@(posedge clk) rst ##1 (!rst && !mem_busy) |=> ni)
        else begin
            fail_count++;
            $error("FAILED %0t: no ni after reset", $time);
        end

    a_entry_op: assert property (@(posedge clk) disable iff (rst)
        ni && !mem_busy ##1 (!mem_busy && nmi_n && firq_n && irq_n) ##1 !mem_busy
        |=> {buserror, cw} == first_word($past(op, 2)))
        else begin
            fail_count++;
            $error("FAILED %0t: wrong first word", $time);
        end

    a_entry_nmi: assert property (@(posedge clk) disable iff (rst)
        ni && !mem_busy ##1 (!mem_busy && !nmi_n) ##1 !mem_busy
        |=> int_en && intvec == 4'b0100)
        else begin
            fail_count++;
            $error("FAILED %0t: nmi entry, intvec %b", $time, intvec);
        end

    a_entry_firq: assert property (@(posedge clk) disable iff (rst)
        ni && !mem_busy ##1 (!mem_busy && nmi_n && !firq_n) ##1 !mem_busy
        |=> int_en && intvec == 4'b0010)
        else begin
            fail_count++;
            $error("FAILED %0t: firq entry, intvec %b", $time, intvec);
        end

    a_entry_irq: assert property (@(posedge clk) disable iff (rst)
        ni && !mem_busy ##1 (!mem_busy && nmi_n && firq_n && !irq_n) ##1 !mem_busy
        |=> int_en && intvec == 4'b0001)
        else begin
            fail_count++;
            $error("FAILED %0t: irq entry, intvec %b", $time, intvec);
        end

    a_idx_fields: assert property (@(posedge clk) disable iff (rst)
        idx_jmp && !mem_busy |=> idx_rsel == $past(mdata[6:4]) && idx_asel == $past(mdata[1:0]))
        else begin
            fail_count++;
            $error("FAILED %0t: indexed fields", $time);
        end

    // a bad postbyte stops the sequencer, a good one does not
    a_idx_err: assert property (@(posedge clk) disable iff (rst)
        idx_jmp && !mem_busy |=> buserror == !postbyte_ok($past(mdata)))
        else begin
            fail_count++;
            $error("FAILED %0t: postbyte bus error %b", $time, buserror);
        end

    a_idx_ret: assert property (@(posedge clk) disable iff (rst)
        idx_ret && !mem_busy |=> idx_post)
        else begin
            fail_count++;
            $error("FAILED %0t: idx_post missing", $time);
        end

    a_idx_pulse: assert property (@(posedge clk) disable iff (rst) idx_post |=> !idx_post)
        else begin
            fail_count++;
            $error("FAILED %0t: idx_post longer than a cycle", $time);
        end

    // routine after the detour follows the opcode
    a_idx_next: assert property (@(posedge clk) disable iff (rst)
        idx_post && !mem_busy
        |=> ni && up_lda == ($past(op) == LDA_IDX) && we == ($past(op) == STA))
        else begin
            fail_count++;
            $error("FAILED %0t: word after detour", $time);
        end

    a_busy_hold: assert property (@(posedge clk) disable iff (rst)
        mem_busy |=> cw == $past(cw))
        else begin
            fail_count++;
            $error("FAILED %0t: strobes moved while busy", $time);
        end

    a_err_stuck: assert property (@(posedge clk) disable iff (rst)
        buserror |=> buserror && !ni)
        else begin
            fail_count++;
            $error("FAILED %0t: bus error released", $time);
        end

endmodule

`default_nettype wire
